// ==== verilog/lane_sram_pkg.sv ====
// Lane SRAM shared types

package lane_sram_pkg;

  // Word address bits
  localparam int ADDR_WIDTH = 6;

  // Independently writable lanes per word
  localparam int NUM_LANES = 4;

  // Bits per lane
  localparam int LANE_WIDTH = 4;

  // Full word, all lanes side by side
  localparam int DATA_WIDTH = NUM_LANES * LANE_WIDTH;

  // Word address
  typedef logic [ADDR_WIDTH-1:0] sram_addr_t;

  // Full data word
  typedef logic [DATA_WIDTH-1:0] sram_data_t;

  // One lane slice
  typedef logic [LANE_WIDTH-1:0] lane_data_t;

  // Lane select, active high at the request port
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // Request as queued and dequeued
  typedef struct packed {
    logic       write;
    sram_addr_t addr;
    sram_data_t wdata;
    lane_mask_t mask;
  } sram_req_t;

  // Read response payload
  typedef struct packed {
    sram_data_t rdata;
  } sram_rsp_t;

endpackage

// ==== verilog/fpga_ram.sv ====
// Behavioral single-port RAM

`timescale 1ns/1ps

module fpga_ram #(
  parameter int DATA_W = 4,
  parameter int ADDR_W = 6
) (
  input  logic              CLK,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] din,
  input  logic              we,
  output logic [DATA_W-1:0] dout
);

  // One word per address
  localparam int DEPTH = 2 ** ADDR_W;

  // Storage array, contents undefined after power-up
  logic [DATA_W-1:0] mem [DEPTH];

  // Synchronous write
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
  end

  // Registered read on every edge
  // Old word comes out on a write cycle
  // Held address keeps the output steady while idle
  always_ff @(posedge CLK) begin
    dout <= mem[addr];
  end

endmodule

// ==== verilog/spsram_lane_wrap.sv ====
// SRAM macro wrapper

`timescale 1ns/1ps

module spsram_lane_wrap (
  input  logic                     CLK,
  input  lane_sram_pkg::sram_addr_t a,
  input  logic                     cen,
  input  logic                     gwen,
  input  lane_sram_pkg::lane_mask_t wen,
  input  lane_sram_pkg::sram_data_t d,
  output lane_sram_pkg::sram_data_t q
);

  import lane_sram_pkg::*;

  // Last address seen with the chip enabled
  sram_addr_t addr_hold;

  // Address actually presented to the lane RAMs
  sram_addr_t ram_addr;

  // Capture address on every enabled cycle
  always_ff @(posedge CLK) begin
    if (!cen) begin
      addr_hold <= a;
    end
  end

  // Deselected chip sees the held address
  // so the read register keeps returning the same word
  assign ram_addr = cen ? addr_hold : a;

  // One RAM per lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    logic       lane_we;
    lane_data_t lane_din;
    lane_data_t lane_dout;

    // All three selects active low
    assign lane_we = !cen && !gwen && !wen[i];

    // Lane slice of the write word
    assign lane_din = d[i*LANE_WIDTH +: LANE_WIDTH];

    fpga_ram #(
      .DATA_W(LANE_WIDTH),
      .ADDR_W(ADDR_WIDTH)
    ) u_ram (
      .CLK (CLK),
      .addr(ram_addr),
      .din (lane_din),
      .we  (lane_we),
      .dout(lane_dout)
    );

    // Reassemble read word, lane 0 in the low bits
    assign q[i*LANE_WIDTH +: LANE_WIDTH] = lane_dout;
  end

endmodule

// ==== verilog/sram_req_queue.sv ====
// Credit-backed request queue

`timescale 1ns/1ps

module sram_req_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     CLK,
  input  logic                     rst,
  input  logic                     req_valid,
  input  lane_sram_pkg::sram_req_t req,
  output logic                     deq_valid,
  output lane_sram_pkg::sram_req_t deq_req,
  output logic                     credit_return
);

  import lane_sram_pkg::*;

  // Pointer wraps naturally, depth is a power of two
  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  // One extra bit to represent a full queue
  localparam int CNT_W = PTR_W + 1;

  // Entry storage, no reset needed
  sram_req_t mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  // Credit rule guarantees space for every request
  assign push = req_valid;

  // Controller never stalls, so pop whenever non-empty
  assign pop = (count != '0);

  // Head entry straight out to the controller
  assign deq_valid = pop;
  assign deq_req   = mem[rd_ptr];

  // Write side
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= req;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      // Simultaneous push and pop leaves count alone
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // One credit back per dequeue, a cycle later
  always_ff @(posedge CLK) begin
    if (rst) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
    end
  end

endmodule

// ==== verilog/sram_access_ctrl.sv ====
// SRAM access controller

`timescale 1ns/1ps

module sram_access_ctrl (
  input  logic                      CLK,
  input  logic                      rst,
  input  logic                      deq_valid,
  input  lane_sram_pkg::sram_req_t  deq_req,
  output lane_sram_pkg::sram_addr_t a,
  output logic                      cen,
  output logic                      gwen,
  output lane_sram_pkg::lane_mask_t wen,
  output lane_sram_pkg::sram_data_t d,
  input  lane_sram_pkg::sram_data_t q,
  output logic                      rsp_valid,
  output lane_sram_pkg::sram_rsp_t  rsp
);

  import lane_sram_pkg::*;

  // Read going to the macro this cycle
  logic rd_issue;

  // Read issued last cycle, q valid now
  logic rd_pending;

  // Every dequeued entry is one macro cycle
  assign cen = !deq_valid;

  // Global write enable only for a live write
  assign gwen = !(deq_valid && deq_req.write);

  // Lane selects flip to the macro's active-low sense
  assign wen = ~deq_req.mask;

  // Address and write data pass from the entry
  assign a = deq_req.addr;
  assign d = deq_req.wdata;

  // Reads only, writes return nothing
  assign rd_issue = deq_valid && !deq_req.write;

  // Track the single read in the RAM pipeline
  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= rd_issue;
    end
  end

  // Response lines up with the RAM read register
  // Order follows issue order since the RAM has a fixed one-cycle latency
  assign rsp_valid = rd_pending;

  always_comb begin
    rsp       = '0;
    rsp.rdata = q;
  end

endmodule

// ==== verilog/lane_sram_top.sv ====
// Lane SRAM scratchpad top

`timescale 1ns/1ps

module lane_sram_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     CLK,
  input  logic                     rst,
  input  logic                     req_valid,
  input  lane_sram_pkg::sram_req_t req,
  output logic                     credit_return,
  output logic                     rsp_valid,
  output lane_sram_pkg::sram_rsp_t rsp
);

  import lane_sram_pkg::*;

  // Queue to controller
  logic      deq_valid;
  sram_req_t deq_req;

  // Controller to macro
  sram_addr_t mac_a;
  logic       mac_cen;
  logic       mac_gwen;
  lane_mask_t mac_wen;
  sram_data_t mac_d;
  sram_data_t mac_q;

  // Request buffering and credit return
  sram_req_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_queue (
    .CLK          (CLK),
    .rst          (rst),
    .req_valid    (req_valid),
    .req          (req),
    .deq_valid    (deq_valid),
    .deq_req      (deq_req),
    .credit_return(credit_return)
  );

  // Macro sequencing and responses
  sram_access_ctrl u_ctrl (
    .CLK      (CLK),
    .rst      (rst),
    .deq_valid(deq_valid),
    .deq_req  (deq_req),
    .a        (mac_a),
    .cen      (mac_cen),
    .gwen     (mac_gwen),
    .wen      (mac_wen),
    .d        (mac_d),
    .q        (mac_q),
    .rsp_valid(rsp_valid),
    .rsp      (rsp)
  );

  // Storage
  spsram_lane_wrap u_sram (
    .CLK (CLK),
    .a   (mac_a),
    .cen (mac_cen),
    .gwen(mac_gwen),
    .wen (mac_wen),
    .d   (mac_d),
    .q   (mac_q)
  );

endmodule

// ==== tests/lane_sram_sva.sv ====
// Lane SRAM bound assertions

`timescale 1ns/1ps

module lane_sram_sva #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic                          CLK,
  input logic                          rst,
  input logic [$clog2(QUEUE_DEPTH):0]  count,
  input logic                          credit_return,
  input logic                          rd_issue,
  input logic                          rsp_valid
);

  // Credit rule keeps the queue from overfilling
  count_within_depth: assert property (
    @(posedge CLK) disable iff (rst) count <= QUEUE_DEPTH
  ) else $error("queue count %0d above depth %0d", count, QUEUE_DEPTH);

  // First cycle out of reset carries no credit
  no_credit_after_reset: assert property (
    @(posedge CLK) $fell(rst) |-> !credit_return
  ) else $error("credit_return high right after reset");

  // Response only in the cycle after a read reaches the macro
  rsp_follows_read: assert property (
    @(posedge CLK) disable iff (rst) rsp_valid |-> $past(rd_issue)
  ) else $error("rsp_valid without a read issued the cycle before");

  // Every macro read gets its response next cycle
  read_gets_rsp: assert property (
    @(posedge CLK) disable iff (rst) rd_issue |=> rsp_valid
  ) else $error("read issued but rsp_valid missing one cycle later");

endmodule

// Queue occupancy and its credit output
bind sram_req_queue lane_sram_sva #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_sva (
  .CLK(CLK), .rst(rst), .count(count), .credit_return(credit_return),
  .rd_issue(1'b0), .rsp_valid(1'b0)
);

// Read as driven on the macro pins against response timing
bind sram_access_ctrl lane_sram_sva u_ctrl_sva (
  .CLK(CLK), .rst(rst), .count('0), .credit_return(1'b0),
  .rd_issue(!cen && gwen), .rsp_valid(rsp_valid)
);

// Credit port as seen at the top level
bind lane_sram_top lane_sram_sva #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_top_sva (
  .CLK(CLK), .rst(rst), .count('0), .credit_return(credit_return),
  .rd_issue(1'b0), .rsp_valid(1'b0)
);

// ==== tests/lane_sram_tb.sv ====
// Lane SRAM scratchpad testbench

`timescale 1ns/1ps

module lane_sram_tb;

  import lane_sram_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  // Upper bound for any single wait, in cycles
  localparam int TIMEOUT_CYCLES = 200;

  logic      CLK;
  logic      rst;
  logic      req_valid;
  sram_req_t req;
  logic      credit_return;
  logic      rsp_valid;
  sram_rsp_t rsp;

  // Requester credit model
  int credits;
  int errors;
  int checks;
  int tests_run;
  bit stalled;

  // Expected read data, oldest first
  sram_data_t exp_q[$];

  lane_sram_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) DUT (
    .CLK          (CLK),
    .rst          (rst),
    .req_valid    (req_valid),
    .req          (req),
    .credit_return(credit_return),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp)
  );

  // 10 ns clock
  always #5 CLK = ~CLK;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Outputs sampled mid-cycle, away from both edges
  always @(negedge CLK) begin : monitor
    sram_data_t head;
    if (!rst) begin
      if (credit_return) begin
        credits++;
      end
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a response arrived at %0t with no read outstanding", $time);
        end else begin
          head = exp_q.pop_front();
          check_value(rsp.rdata, head, "read data");
        end
      end
    end
  end

  // Called 1 ns after a rising edge, returns at the same phase
  task automatic send_request(input sram_req_t r, input sram_data_t exp_rdata);
    int waited;
    waited = 0;
    while (credits == 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      #1;
      waited++;
    end
    if (credits == 0) begin
      errors++;
      stalled = 1'b1;
      $display("no credit came back within %0d cycles, request not sent", TIMEOUT_CYCLES);
    end else begin
      if (!r.write) begin
        exp_q.push_back(exp_rdata);
      end
      req_valid = 1'b1;
      req       = r;
      credits--;
      @(posedge CLK);
      #1;
      req_valid = 1'b0;
    end
  endtask

  // Drain outstanding reads, then report the test
  task automatic finish_test(input int id, input int first_err, input int n_req);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      stalled = 1'b1;
      $display("test %0d: %0d read responses never arrived", id, exp_q.size());
    end
    tests_run++;
    $display("test %0d done: %0d requests, %0d errors", id, n_req, errors - first_err);
  endtask

  initial begin : main
    int        fd;
    int        rc;
    int        waited;
    string     line;
    int        id;
    int        op;
    int        f_addr;
    int        f_wdata;
    int        f_mask;
    int        f_exp;
    int        cur_id;
    int        first_err;
    int        n_req;
    sram_req_t r;

    CLK       = 1'b0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    credits   = QUEUE_DEPTH;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    stalled   = 1'b0;
    cur_id    = -1;
    first_err = 0;
    n_req     = 0;

    // Ten cycles of reset
    repeat (10) @(posedge CLK);
    #1;
    rst = 1'b0;

    fd = $fopen("tests/lane_sram_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the cases file tests/lane_sram_cases.txt");
    end else begin
      while (!stalled) begin
        rc = $fgets(line, fd);
        if (rc == 0) begin
          break;
        end
        // Skip blank and comment lines
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        rc = $sscanf(line, "%d %d %h %h %h %h", id, op, f_addr, f_wdata, f_mask, f_exp);
        if (rc != 6) begin
          errors++;
          $display("cases file line could not be parsed: %s", line);
          continue;
        end
        // New test id closes the previous test
        if (id != cur_id) begin
          if (cur_id >= 0) begin
            finish_test(cur_id, first_err, n_req);
          end
          cur_id    = id;
          first_err = errors;
          n_req     = 0;
        end
        r.write = (op != 0);
        r.addr  = sram_addr_t'(f_addr);
        r.wdata = sram_data_t'(f_wdata);
        r.mask  = lane_mask_t'(f_mask);
        n_req++;
        send_request(r, sram_data_t'(f_exp));
      end
      $fclose(fd);
      if (cur_id >= 0 && !stalled) begin
        finish_test(cur_id, first_err, n_req);
      end
    end

    // Idle until every credit is home
    waited = 0;
    while (credits < QUEUE_DEPTH && waited < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      #1;
      waited++;
    end
    check_value(credits, QUEUE_DEPTH, "credit count after drain");

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== lane_sram.f ====
verilog/lane_sram_pkg.sv
verilog/fpga_ram.sv
verilog/spsram_lane_wrap.sv
verilog/sram_req_queue.sv
verilog/sram_access_ctrl.sv
verilog/lane_sram_top.sv
tests/lane_sram_sva.sv
tests/lane_sram_tb.sv

// ==== Bender.yml ====
package:
  name: lane_sram

sources:
  # Shared types first, then leaf to top
  - verilog/lane_sram_pkg.sv
  - verilog/fpga_ram.sv
  - verilog/spsram_lane_wrap.sv
  - verilog/sram_req_queue.sv
  - verilog/sram_access_ctrl.sv
  - verilog/lane_sram_top.sv

  # Simulation only
  - target: test
    files:
      - tests/lane_sram_sva.sv
      - tests/lane_sram_tb.sv

// ==== tests/lane_sram_cases.txt ====
# test op(1=write 0=read) addr(hex) wdata(hex) mask(hex, bit i = lane i) expected_rdata(hex)
# Lane 0 is the low nibble; expected column is ignored for writes
1 1 05 a5c3 f 0000
1 0 05 0000 0 a5c3
1 1 2a 1234 f 0000
1 0 2a 0000 0 1234
2 1 10 abcd f 0000
2 1 10 1234 5 0000
2 0 10 0000 0 a2c4
2 1 10 7000 8 0000
2 0 10 0000 0 72c4
2 1 10 0090 2 0000
2 0 10 0000 0 7294
3 1 20 5a5a f 0000
3 0 20 0000 0 5a5a
3 1 20 ffff 0 0000
3 0 20 0000 0 5a5a
3 1 10 0000 0 0000
3 0 10 0000 0 7294
4 1 30 beef f 0000
4 0 30 0000 0 beef
4 1 30 0f00 4 0000
4 0 30 0000 0 bfef
5 0 05 0000 0 a5c3
5 0 2a 0000 0 1234
5 0 10 0000 0 7294
5 0 20 0000 0 5a5a
6 1 00 1111 f 0000
6 1 01 2222 f 0000
6 0 00 0000 0 1111
6 1 00 cccc 3 0000
6 0 01 0000 0 2222
6 0 00 0000 0 11cc
6 1 3f 9876 f 0000
6 0 3f 0000 0 9876
